//--- hw/cube_dma_pkg.sv
package cube_dma_pkg;

    // Byte address and memory word widths
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Channel, row, column and offset fields
    localparam int cube_width = 16;

    // Word offset to byte offset
    localparam int word_shift = 2;

    // Read data buffering between the read and write sides
    localparam int fifo_depth = 8;

    // Must hold the value fifo_depth itself
    localparam int fifo_cnt_width = 4;

endpackage

//--- hw/word_fifo.sv
`timescale 1ns/100ps

module word_fifo #(
    parameter int depth = cube_dma_pkg::fifo_depth
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    push,
    input  logic [cube_dma_pkg::data_width-1:0]     push_data,
    input  logic                                    pop,
    output logic [cube_dma_pkg::data_width-1:0]     pop_data,
    output logic                                    full,
    output logic                                    empty,
    output logic [cube_dma_pkg::fifo_cnt_width-1:0] count
);

    logic [cube_dma_pkg::data_width-1:0] mem [depth];
    logic [$clog2(depth)-1:0]            wr_ptr;
    logic [$clog2(depth)-1:0]            rd_ptr;

    // Data array write port
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word shows as soon as it is stored
    assign pop_data = mem[rd_ptr];
    assign full     = (count == depth);
    assign empty    = (count == 0);

    // Reader reserves space before each read, so overflow means a broken reservation
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

//--- hw/cube_walker.sv
`timescale 1ns/100ps

module cube_walker (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic [cube_dma_pkg::addr_width-1:0] src_base,
    input  logic [cube_dma_pkg::addr_width-1:0] dst_base,
    input  logic [cube_dma_pkg::cube_width-1:0] channel,
    input  logic [cube_dma_pkg::cube_width-1:0] row,
    input  logic [cube_dma_pkg::cube_width-1:0] col,
    input  logic [cube_dma_pkg::cube_width-1:0] channel_offset,
    input  logic [cube_dma_pkg::cube_width-1:0] row_offset,
    input  logic                                desc_ready,
    input  logic                                row_done,
    output logic                                busy,
    output logic                                done,
    output logic                                desc_valid,
    output logic [cube_dma_pkg::addr_width-1:0] desc_src,
    output logic [cube_dma_pkg::addr_width-1:0] desc_dst,
    output logic [cube_dma_pkg::cube_width-1:0] desc_len
);

    // Latched configuration
    logic [cube_dma_pkg::addr_width-1:0] src_base_reg;
    logic [cube_dma_pkg::addr_width-1:0] dst_base_reg;
    logic [cube_dma_pkg::cube_width-1:0] channel_reg;
    logic [cube_dma_pkg::cube_width-1:0] row_reg;
    logic [cube_dma_pkg::cube_width-1:0] col_reg;
    logic [cube_dma_pkg::cube_width-1:0] chan_off_reg;
    logic [cube_dma_pkg::cube_width-1:0] row_off_reg;

    // Widened copies for the stride arithmetic
    logic [cube_dma_pkg::addr_width-1:0] row_ext;
    logic [cube_dma_pkg::addr_width-1:0] col_ext;
    logic [cube_dma_pkg::addr_width-1:0] row_off_ext;
    logic [cube_dma_pkg::addr_width-1:0] chan_off_ext;
    logic [cube_dma_pkg::addr_width-1:0] row_words;
    logic [cube_dma_pkg::addr_width-1:0] chan_words;

    // Byte strides and running channel bases
    logic [cube_dma_pkg::addr_width-1:0] row_step;
    logic [cube_dma_pkg::addr_width-1:0] chan_step;
    logic [cube_dma_pkg::addr_width-1:0] chan_src;
    logic [cube_dma_pkg::addr_width-1:0] chan_dst;

    logic [cube_dma_pkg::cube_width-1:0] row_cnt;
    logic [cube_dma_pkg::cube_width-1:0] chan_cnt;
    logic                                setup;
    logic                                start_ok;
    logic                                zero_dim;
    logic                                last_row;
    logic                                last_chan;

    assign start_ok  = start && !busy;
    assign zero_dim  = (channel_reg == '0) || (row_reg == '0) || (col_reg == '0);
    assign last_row  = (row_cnt == row_reg - 1'b1);
    assign last_chan = (chan_cnt == channel_reg - 1'b1);

    assign row_ext      = {{(cube_dma_pkg::addr_width - cube_dma_pkg::cube_width){1'b0}}, row_reg};
    assign col_ext      = {{(cube_dma_pkg::addr_width - cube_dma_pkg::cube_width){1'b0}}, col_reg};
    assign row_off_ext  = {{(cube_dma_pkg::addr_width - cube_dma_pkg::cube_width){1'b0}},
                           row_off_reg};
    assign chan_off_ext = {{(cube_dma_pkg::addr_width - cube_dma_pkg::cube_width){1'b0}},
                           chan_off_reg};

    // Words per row slot and per channel slot use the only multiply
    assign row_words  = col_ext + row_off_ext;
    assign chan_words = row_ext * row_words + chan_off_ext;

    assign desc_len = col_reg;

    // Setup cycle, descriptor handshake and wait for row completion
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            setup      <= 1'b0;
            desc_valid <= 1'b0;
            done       <= 1'b0;
            row_cnt    <= '0;
            chan_cnt   <= '0;
        end else begin
            done <= 1'b0;
            if (start_ok) begin
                busy     <= 1'b1;
                setup    <= 1'b1;
                row_cnt  <= '0;
                chan_cnt <= '0;
            end else if (setup) begin
                setup <= 1'b0;
                if (zero_dim) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    desc_valid <= 1'b1;
                end
            end else if (desc_valid && desc_ready) begin
                desc_valid <= 1'b0;
            end else if (row_done) begin
                if (last_row && last_chan) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    desc_valid <= 1'b1;
                    if (last_row) begin
                        row_cnt  <= '0;
                        chan_cnt <= chan_cnt + 1'b1;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            src_base_reg <= src_base;
            dst_base_reg <= dst_base;
            channel_reg  <= channel;
            row_reg      <= row;
            col_reg      <= col;
            chan_off_reg <= channel_offset;
            row_off_reg  <= row_offset;
        end
        if (setup) begin
            row_step  <= row_words << cube_dma_pkg::word_shift;
            chan_step <= chan_words << cube_dma_pkg::word_shift;
            desc_src  <= src_base_reg;
            desc_dst  <= dst_base_reg;
            chan_src  <= src_base_reg;
            chan_dst  <= dst_base_reg;
        end else if (busy && row_done) begin
            if (last_row) begin
                // Next channel starts one channel stride past the previous channel base
                chan_src <= chan_src + chan_step;
                chan_dst <= chan_dst + chan_step;
                desc_src <= chan_src + chan_step;
                desc_dst <= chan_dst + chan_step;
            end else begin
                desc_src <= desc_src + row_step;
                desc_dst <= desc_dst + row_step;
            end
        end
    end

    a_desc_stable: assert property (@(posedge clk) disable iff (rst)
        desc_valid && !desc_ready |=> desc_valid && $stable(desc_src) && $stable(desc_dst)
            && $stable(desc_len));

    // Engine completions only while a cube is being walked
    a_no_idle_row_done: assert property (@(posedge clk) disable iff (rst)
        row_done |-> busy && !setup && !desc_valid);

endmodule

//--- hw/row_copy_engine.sv
`timescale 1ns/100ps

module row_copy_engine (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                desc_valid,
    input  logic [cube_dma_pkg::addr_width-1:0] desc_src,
    input  logic [cube_dma_pkg::addr_width-1:0] desc_dst,
    input  logic [cube_dma_pkg::cube_width-1:0] desc_len,
    input  logic                                rd_ready,
    input  logic                                rd_data_valid,
    input  logic [cube_dma_pkg::data_width-1:0] rd_data,
    input  logic                                wr_ready,
    output logic                                desc_ready,
    output logic                                row_done,
    output logic                                rd_valid,
    output logic [cube_dma_pkg::addr_width-1:0] rd_addr,
    output logic                                wr_valid,
    output logic [cube_dma_pkg::addr_width-1:0] wr_addr,
    output logic [cube_dma_pkg::data_width-1:0] wr_data
);

    logic                                    active;
    logic [cube_dma_pkg::cube_width-1:0]     rd_left;
    logic [cube_dma_pkg::cube_width-1:0]     wr_left;
    logic [cube_dma_pkg::fifo_cnt_width-1:0] outstanding;
    logic [cube_dma_pkg::fifo_cnt_width-1:0] fifo_count;
    logic                                    fifo_empty;
    logic                                    desc_fire;
    logic                                    rd_fire;
    logic                                    wr_fire;
    logic                                    room;

    // One row at a time
    assign desc_ready = !active;
    assign desc_fire  = desc_valid && desc_ready;

    // Every word in the FIFO or still in flight holds a slot
    assign room = (fifo_count + outstanding < cube_dma_pkg::fifo_depth);

    assign rd_valid = active && (rd_left != '0) && room;
    assign rd_fire  = rd_valid && rd_ready;

    assign wr_valid = active && !fifo_empty;
    assign wr_fire  = wr_valid && wr_ready;

    // Last write of the row accepted this cycle
    assign row_done = wr_fire && (wr_left == 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active      <= 1'b0;
            rd_left     <= '0;
            wr_left     <= '0;
            outstanding <= '0;
        end else begin
            if (desc_fire) begin
                active  <= 1'b1;
                rd_left <= desc_len;
                wr_left <= desc_len;
            end else begin
                if (rd_fire) begin
                    rd_left <= rd_left - 1'b1;
                end
                if (wr_fire) begin
                    wr_left <= wr_left - 1'b1;
                end
                if (row_done) begin
                    active <= 1'b0;
                end
            end
            case ({rd_fire, rd_data_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Address walk through consecutive words
    always_ff @(posedge clk) begin
        if (desc_fire) begin
            rd_addr <= desc_src;
            wr_addr <= desc_dst;
        end else begin
            if (rd_fire) begin
                rd_addr <= rd_addr + (1 << cube_dma_pkg::word_shift);
            end
            if (wr_fire) begin
                wr_addr <= wr_addr + (1 << cube_dma_pkg::word_shift);
            end
        end
    end

    word_fifo #(
        .depth     (cube_dma_pkg::fifo_depth)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (rd_data_valid),
        .push_data (rd_data),
        .pop       (wr_fire),
        .pop_data  (wr_data),
        .full      (),
        .empty     (fifo_empty),
        .count     (fifo_count)
    );

    // Memory returns only what was asked for
    a_no_stray_data: assert property (@(posedge clk) disable iff (rst)
        rd_data_valid |-> outstanding != '0);

endmodule

//--- hw/cube_dma_top.sv
`timescale 1ns/100ps

module cube_dma_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic [cube_dma_pkg::addr_width-1:0] src_base,
    input  logic [cube_dma_pkg::addr_width-1:0] dst_base,
    input  logic [cube_dma_pkg::cube_width-1:0] channel,
    input  logic [cube_dma_pkg::cube_width-1:0] row,
    input  logic [cube_dma_pkg::cube_width-1:0] col,
    input  logic [cube_dma_pkg::cube_width-1:0] channel_offset,
    input  logic [cube_dma_pkg::cube_width-1:0] row_offset,
    input  logic                                rd_ready,
    input  logic                                rd_data_valid,
    input  logic [cube_dma_pkg::data_width-1:0] rd_data,
    input  logic                                wr_ready,
    output logic                                busy,
    output logic                                done,
    output logic                                rd_valid,
    output logic [cube_dma_pkg::addr_width-1:0] rd_addr,
    output logic                                wr_valid,
    output logic [cube_dma_pkg::addr_width-1:0] wr_addr,
    output logic [cube_dma_pkg::data_width-1:0] wr_data
);

    // Row descriptor and completion between walker and engine
    logic                                desc_valid;
    logic                                desc_ready;
    logic [cube_dma_pkg::addr_width-1:0] desc_src;
    logic [cube_dma_pkg::addr_width-1:0] desc_dst;
    logic [cube_dma_pkg::cube_width-1:0] desc_len;
    logic                                row_done;

    cube_walker u_walker (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .src_base       (src_base),
        .dst_base       (dst_base),
        .channel        (channel),
        .row            (row),
        .col            (col),
        .channel_offset (channel_offset),
        .row_offset     (row_offset),
        .desc_ready     (desc_ready),
        .row_done       (row_done),
        .busy           (busy),
        .done           (done),
        .desc_valid     (desc_valid),
        .desc_src       (desc_src),
        .desc_dst       (desc_dst),
        .desc_len       (desc_len)
    );

    row_copy_engine u_engine (
        .clk           (clk),
        .rst           (rst),
        .desc_valid    (desc_valid),
        .desc_src      (desc_src),
        .desc_dst      (desc_dst),
        .desc_len      (desc_len),
        .rd_ready      (rd_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .wr_ready      (wr_ready),
        .desc_ready    (desc_ready),
        .row_done      (row_done),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

endmodule

//--- test/cube_dma_mem.sv
`timescale 1ns/100ps

module cube_dma_mem (
    input  logic                                clk,
    input  logic                                stall_en,
    input  logic                                rd_valid,
    input  logic [cube_dma_pkg::addr_width-1:0] rd_addr,
    output logic                                rd_ready,
    output logic                                rd_data_valid,
    output logic [cube_dma_pkg::data_width-1:0] rd_data,
    input  logic                                wr_valid,
    input  logic [cube_dma_pkg::addr_width-1:0] wr_addr,
    input  logic [cube_dma_pkg::data_width-1:0] wr_data,
    output logic                                wr_ready
);

    localparam int words = 4096;

    logic [cube_dma_pkg::data_width-1:0] mem [words];
    int                                  wr_hits [words];
    int                                  wr_total;
    int                                  bad_access;

    // Pending read returns in request order with their due cycles
    logic [cube_dma_pkg::data_width-1:0] ret_data [$];
    int                                  ret_due [$];
    int                                  cycle;
    int                                  last_due;

    function automatic bit word_ok(input logic [cube_dma_pkg::addr_width-1:0] addr);
        return (addr[cube_dma_pkg::word_shift-1:0] == '0)
            && ((addr >> cube_dma_pkg::word_shift) < words);
    endfunction

    initial begin
        rd_ready      = 1'b0;
        rd_data_valid = 1'b0;
        rd_data       = '0;
        wr_ready      = 1'b0;
        wr_total      = 0;
        bad_access    = 0;
        cycle         = 0;
        last_due      = 0;
    end

    // Handshakes are settled by the falling edge
    always @(negedge clk) begin
        int due;
        if (rd_valid && rd_ready) begin
            due = cycle + $urandom_range(4, 1);
            // Keep returns in request order
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            ret_due.push_back(due);
            if (word_ok(rd_addr)) begin
                ret_data.push_back(mem[rd_addr >> cube_dma_pkg::word_shift]);
            end else begin
                ret_data.push_back('x);
                bad_access = bad_access + 1;
            end
        end
        if (wr_valid && wr_ready) begin
            wr_total = wr_total + 1;
            if (word_ok(wr_addr)) begin
                mem[wr_addr >> cube_dma_pkg::word_shift] = wr_data;
                wr_hits[wr_addr >> cube_dma_pkg::word_shift] =
                    wr_hits[wr_addr >> cube_dma_pkg::word_shift] + 1;
            end else begin
                bad_access = bad_access + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        #2;
        rd_data_valid = 1'b0;
        if (ret_due.size() > 0 && ret_due[0] <= cycle) begin
            rd_data_valid = 1'b1;
            rd_data       = ret_data.pop_front();
            void'(ret_due.pop_front());
        end
        rd_ready = !stall_en || ($urandom_range(3, 0) != 0);
        wr_ready = !stall_en || ($urandom_range(2, 0) != 0);
    end

endmodule

//--- test/cube_dma_tb.sv
`timescale 1ns/100ps

module cube_dma_tb;

    localparam int mem_words = 4096;

    logic                                clk;
    logic                                rst;
    logic                                start;
    logic                                stall_en;
    logic [cube_dma_pkg::addr_width-1:0] src_base;
    logic [cube_dma_pkg::addr_width-1:0] dst_base;
    logic [cube_dma_pkg::cube_width-1:0] channel;
    logic [cube_dma_pkg::cube_width-1:0] row;
    logic [cube_dma_pkg::cube_width-1:0] col;
    logic [cube_dma_pkg::cube_width-1:0] channel_offset;
    logic [cube_dma_pkg::cube_width-1:0] row_offset;
    logic                                rd_ready;
    logic                                rd_data_valid;
    logic [cube_dma_pkg::data_width-1:0] rd_data;
    logic                                wr_ready;
    logic                                busy;
    logic                                done;
    logic                                rd_valid;
    logic [cube_dma_pkg::addr_width-1:0] rd_addr;
    logic                                wr_valid;
    logic [cube_dma_pkg::addr_width-1:0] wr_addr;
    logic [cube_dma_pkg::data_width-1:0] wr_data;

    // Expected memory image and the words that must be written once
    logic [cube_dma_pkg::data_width-1:0] ref_mem [mem_words];
    int                                  exp_write [mem_words];
    int                                  cycles;
    int                                  cycle_limit;
    int                                  done_count;
    int                                  rd_cycles;
    int                                  wr_cycles;

    always #10 clk = ~clk;

    cube_dma_top UUT (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .src_base       (src_base),
        .dst_base       (dst_base),
        .channel        (channel),
        .row            (row),
        .col            (col),
        .channel_offset (channel_offset),
        .row_offset     (row_offset),
        .rd_ready       (rd_ready),
        .rd_data_valid  (rd_data_valid),
        .rd_data        (rd_data),
        .wr_ready       (wr_ready),
        .busy           (busy),
        .done           (done),
        .rd_valid       (rd_valid),
        .rd_addr        (rd_addr),
        .wr_valid       (wr_valid),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data)
    );

    cube_dma_mem u_mem (
        .clk           (clk),
        .stall_en      (stall_en),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .rd_ready      (rd_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_ready      (wr_ready)
    );

    // Limit grows with every cube that is started
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            done_count = done_count + (done ? 1 : 0);
            rd_cycles  = rd_cycles + (rd_valid ? 1 : 0);
            wr_cycles  = wr_cycles + (wr_valid ? 1 : 0);
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic run_cube(input int ch, input int rw, input int cl, input int ro,
                            input int co, input bit stalls, input bit poke);
        int src_w;
        int dst_w;
        int row_words;
        int chan_words;
        int words;
        int off;
        int wait_cycles;
        int i;
        int c;
        int r;
        int k;
        bit done_seen;

        @(posedge clk);
        #2;
        src_w       = $urandom_range(1000, 0);
        dst_w       = 2048 + $urandom_range(1000, 0);
        row_words   = cl + ro;
        chan_words  = rw * row_words + co;
        words       = ch * rw * cl;
        cycle_limit = cycle_limit + 50 * words + 200;

        // Fresh random image with the copy rule applied on top
        for (i = 0; i < mem_words; i++) begin
            u_mem.mem[i]     = $urandom;
            u_mem.wr_hits[i] = 0;
            ref_mem[i]       = u_mem.mem[i];
            exp_write[i]     = 0;
        end
        for (c = 0; c < ch; c++) begin
            for (r = 0; r < rw; r++) begin
                for (k = 0; k < cl; k++) begin
                    off                  = c * chan_words + r * row_words + k;
                    ref_mem[dst_w + off] = ref_mem[src_w + off];
                    exp_write[dst_w + off] = 1;
                end
            end
        end
        u_mem.wr_total = 0;
        done_count     = 0;
        rd_cycles      = 0;
        wr_cycles      = 0;
        stall_en       = stalls;

        src_base       = src_w << cube_dma_pkg::word_shift;
        dst_base       = dst_w << cube_dma_pkg::word_shift;
        channel        = 16'(ch);
        row            = 16'(rw);
        col            = 16'(cl);
        channel_offset = 16'(co);
        row_offset     = 16'(ro);
        start          = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;

        wait_cycles = 0;
        done_seen   = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            wait_cycles = wait_cycles + 1;
            done_seen   = done;
            if (!done_seen) begin
                compare_value("busy", busy, 1);
                @(posedge clk);
                #2;
                // A second start mid-cube with another shape must be dropped
                start = poke && (wait_cycles == 2);
                if (start) begin
                    col      = col + 1'b1;
                    dst_base = dst_base + 32'd4;
                end
            end
        end
        compare_value("busy", busy, 0);
        if (words == 0) begin
            compare_value("cycles from start to done", wait_cycles, 2);
        end

        repeat (4) @(negedge clk);
        compare_value("done pulses", done_count, 1);
        compare_value("busy", busy, 0);
        compare_value("out of range accesses", u_mem.bad_access, 0);
        compare_value("write count", u_mem.wr_total, words);
        if (words == 0) begin
            compare_value("rd_valid cycles", rd_cycles, 0);
            compare_value("wr_valid cycles", wr_cycles, 0);
        end
        for (i = 0; i < mem_words; i++) begin
            compare_value($sformatf("mem[%0d]", i), u_mem.mem[i], ref_mem[i]);
            compare_value($sformatf("writes to word %0d", i), u_mem.wr_hits[i], exp_write[i]);
        end
    endtask

    initial begin
        int n;
        void'($urandom(64334));
        clk            = 1'b0;
        rst            = 1'b1;
        start          = 1'b0;
        stall_en       = 1'b0;
        src_base       = '0;
        dst_base       = '0;
        channel        = '0;
        row            = '0;
        col            = '0;
        channel_offset = '0;
        row_offset     = '0;
        cycles         = 0;
        cycle_limit    = 100;
        done_count     = 0;
        rd_cycles      = 0;
        wr_cycles      = 0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // Outputs idle out of reset
        @(negedge clk);
        compare_value("busy", busy, 0);
        compare_value("done", done, 0);
        compare_value("rd_valid", rd_valid, 0);
        compare_value("wr_valid", wr_valid, 0);

        // Single row
        run_cube(1, 1, 12, 0, 0, 1'b0, 1'b0);
        // Gaps between rows and channels
        for (n = 0; n < 3; n++) begin
            run_cube($urandom_range(3, 1), $urandom_range(4, 1), $urandom_range(8, 1),
                     $urandom_range(3, 1), $urandom_range(5, 1), 1'b0, 1'b0);
        end
        // Memory stalls and variable read latency
        for (n = 0; n < 3; n++) begin
            run_cube($urandom_range(3, 1), $urandom_range(4, 1), $urandom_range(8, 1),
                     $urandom_range(3, 0), $urandom_range(5, 0), 1'b1, 1'b0);
        end
        run_cube(2, 2, 4, 1, 2, 1'b1, 1'b1);
        // Each zero dimension in turn
        run_cube(0, 3, 4, 1, 1, 1'b0, 1'b0);
        run_cube(2, 0, 4, 1, 1, 1'b0, 1'b0);
        run_cube(2, 3, 0, 1, 1, 1'b0, 1'b0);
        for (n = 0; n < 10; n++) begin
            run_cube($urandom_range(3, 1), $urandom_range(4, 1), $urandom_range(8, 1),
                     $urandom_range(3, 0), $urandom_range(5, 0), $urandom_range(1, 0), 1'b0);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- sim.f
hw/cube_dma_pkg.sv
hw/word_fifo.sv
hw/cube_walker.sv
hw/row_copy_engine.sv
hw/cube_dma_top.sv
test/cube_dma_mem.sv
test/cube_dma_tb.sv
